/* logic/z8Pkg.sv */
package z8Pkg;

    typedef logic [7:0] byteT;

    // C sits at bit 7 as in the flag register
    typedef struct packed {
        logic       c;
        logic       z;
        logic       s;
        logic       v;
        logic       d;
        logic       h;
        logic [1:0] spare;
    } flagsT;

    // Binary ops use the opcode high nibble as their code
    typedef enum logic [3:0] {
        AluAdd = 4'h0,
        AluAdc = 4'h1,
        AluSub = 4'h2,
        AluSbc = 4'h3,
        AluOr  = 4'h4,
        AluAnd = 4'h5,
        AluTcm = 4'h6,
        AluTm  = 4'h7,
        AluCp  = 4'hA,
        AluXor = 4'hB,
        AluLd  = 4'hF
    } aluOpT;

    typedef struct packed {
        byteT opcode;
        byteT second;
        byteT third;
    } instrT;

    typedef struct packed {
        logic valid;
        byteT addr;
        byteT data;
    } regWriteT;

    localparam byteT       FlagsAddr   = 8'hFC;
    localparam byteT       RpAddr      = 8'hFD;
    localparam logic [3:0] WorkingPage = 4'hE;

    // Full opcodes
    localparam byteT OpSrp     = 8'h31;
    localparam byteT OpLdRegIm = 8'hE6;
    localparam byteT OpRcf     = 8'hCF;
    localparam byteT OpScf     = 8'hDF;
    localparam byteT OpCcf     = 8'hEF;

    // Low nibble of opcode families
    localparam logic [3:0] NibAluRr     = 4'h2;
    localparam logic [3:0] NibAluIm     = 4'h6;
    localparam logic [3:0] NibLdWorkReg = 4'h8;
    localparam logic [3:0] NibJr        = 4'hB;
    localparam logic [3:0] NibLdWorkIm  = 4'hC;
    localparam logic [3:0] NibJp        = 4'hD;

endpackage

/* logic/aluUnit.sv */
`timescale 1ns/100ps

module aluUnit (
    input  z8Pkg::aluOpT op,
    input  z8Pkg::byteT  a,
    input  z8Pkg::byteT  b,
    input  z8Pkg::flagsT flagsIn,
    output z8Pkg::byteT  result,
    output z8Pkg::flagsT flagsOut,
    output logic         writesResult
);
    import z8Pkg::*;

    logic       carryIn;
    logic [8:0] addSum;
    logic [8:0] subDiff;
    logic       addOvf;
    logic       subOvf;

    assign carryIn = (op == AluAdc || op == AluSbc) ? flagsIn.c : 1'b0;
    assign addSum  = {1'b0, a} + {1'b0, b} + {8'h00, carryIn};
    assign subDiff = {1'b0, a} - {1'b0, b} - {8'h00, carryIn};

    // Signed overflow
    assign addOvf = (a[7] == b[7]) && (addSum[7] != a[7]);
    assign subOvf = (a[7] != b[7]) && (subDiff[7] != a[7]);

    always_comb begin
        result       = b;
        flagsOut     = flagsIn;
        writesResult = 1'b0;
        case (op)
            AluAdd, AluAdc: begin
                result       = addSum[7:0];
                flagsOut.c   = addSum[8];
                flagsOut.v   = addOvf;
                writesResult = 1'b1;
            end
            AluSub, AluSbc, AluCp: begin
                result       = subDiff[7:0];
                flagsOut.c   = subDiff[8];
                flagsOut.v   = subOvf;
                writesResult = op != AluCp;
            end
            AluOr: begin
                result       = a | b;
                flagsOut.v   = 1'b0;
                writesResult = 1'b1;
            end
            AluAnd, AluTm: begin
                result       = a & b;
                flagsOut.v   = 1'b0;
                writesResult = op == AluAnd;
            end
            AluXor: begin
                result       = a ^ b;
                flagsOut.v   = 1'b0;
                writesResult = 1'b1;
            end
            AluTcm: begin
                result     = ~a & b;
                flagsOut.v = 1'b0;
            end
            default: begin
                // ld passes b through with flags untouched
                writesResult = 1'b1;
            end
        endcase
        if (op != AluLd) begin
            flagsOut.z = result == 8'h00;
            flagsOut.s = result[7];
        end
    end

endmodule

/* logic/regFile.sv */
`timescale 1ns/100ps

module regFile #(
    parameter int         numRegs = 128,
    parameter logic [3:0] resetRp = 4'h0
) (
    input  logic            clk,
    input  logic            rstN,
    input  z8Pkg::byteT     readAddrA,
    input  z8Pkg::byteT     readAddrB,
    input  z8Pkg::regWriteT regWrite,
    input  logic            flagsWrite,
    input  z8Pkg::flagsT    flagsNext,
    output z8Pkg::byteT     readDataA,
    output z8Pkg::byteT     readDataB,
    output z8Pkg::flagsT    flags,
    output logic [3:0]      rp
);
    import z8Pkg::*;

    localparam int IdxW = $clog2(numRegs);

    byteT regs [numRegs];

    function automatic byteT readReg(input byteT addr);
        if (addr == FlagsAddr) begin
            return byteT'(flags);
        end else if (addr == RpAddr) begin
            return {rp, 4'h0};
        end else if (int'(addr) < numRegs) begin
            return regs[addr[IdxW-1:0]];
        end
        // Unmapped space
        return 8'h00;
    endfunction

    always_comb begin
        readDataA = readReg(readAddrA);
        readDataB = readReg(readAddrB);
    end

    always_ff @(posedge clk) begin
        if (regWrite.valid && regWrite.addr != FlagsAddr && regWrite.addr != RpAddr
                && int'(regWrite.addr) < numRegs) begin
            regs[regWrite.addr[IdxW-1:0]] <= regWrite.data;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flags <= '0;
            rp    <= resetRp;
        end else begin
            // Explicit write to FC beats the ALU flag update
            if (regWrite.valid && regWrite.addr == FlagsAddr) begin
                flags <= flagsT'(regWrite.data);
            end else if (flagsWrite) begin
                flags <= flagsNext;
            end
            if (regWrite.valid && regWrite.addr == RpAddr) begin
                rp <= regWrite.data[7:4];
            end
        end
    end

endmodule

/* logic/instrFetch.sv */
`timescale 1ns/100ps

module instrFetch #(
    parameter z8Pkg::byteT resetPc = 8'h00
) (
    input  logic         clk,
    input  logic         rstN,
    input  z8Pkg::byteT  memData,
    input  logic         branchTaken,
    input  z8Pkg::byteT  branchTarget,
    output logic         memStrobe,
    output z8Pkg::byteT  memAddr,
    output z8Pkg::instrT instr,
    output logic         decode,
    output z8Pkg::byteT  nextPc
);
    import z8Pkg::*;

    typedef enum logic [2:0] {
        StFetch,
        StReadOp,
        StWait2,
        StRead2,
        StWait3,
        StRead3,
        StDecode
    } stateT;

    stateT state;
    byteT  pc;
    logic  isSize1;
    logic  isSize3;

    // Length from the low nibble of the opcode
    assign isSize1 = instr.opcode[3:1] == 3'b111;
    assign isSize3 = instr.opcode[3:2] == 2'b01 || instr.opcode[3:0] == NibJp;

    assign memStrobe = state == StFetch
                    || (state == StWait2 && !isSize1)
                    || (state == StWait3 && isSize3);
    assign memAddr = pc;
    assign decode  = state == StDecode;
    // pc already points past the instruction by decode
    assign nextPc  = pc;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= StFetch;
            pc    <= resetPc;
        end else begin
            case (state)
                StFetch: begin
                    state <= StReadOp;
                end
                StReadOp: begin
                    state <= StWait2;
                    pc    <= pc + 8'd1;
                end
                StWait2: begin
                    state <= isSize1 ? StDecode : StRead2;
                end
                StRead2: begin
                    state <= StWait3;
                    pc    <= pc + 8'd1;
                end
                StWait3: begin
                    // Two-byte instructions idle here without a strobe
                    state <= isSize3 ? StRead3 : StDecode;
                end
                StRead3: begin
                    state <= StDecode;
                    pc    <= pc + 8'd1;
                end
                StDecode: begin
                    state <= StFetch;
                    if (branchTaken) begin
                        pc <= branchTarget;
                    end
                end
                default: begin
                    state <= StFetch;
                end
            endcase
        end
    end

    // Instruction bytes land in the read cycles
    always_ff @(posedge clk) begin
        case (state)
            StReadOp: instr.opcode <= memData;
            StRead2:  instr.second <= memData;
            StRead3:  instr.third  <= memData;
            default:  ;
        endcase
    end

endmodule

/* logic/execUnit.sv */
`timescale 1ns/100ps

module execUnit #(
    parameter int numRegs = 128
) (
    input  logic            clk,
    input  logic            rstN,
    input  z8Pkg::instrT    instr,
    input  logic            decode,
    input  z8Pkg::byteT     nextPc,
    input  z8Pkg::byteT     readDataA,
    input  z8Pkg::byteT     readDataB,
    input  z8Pkg::flagsT    flags,
    input  logic [3:0]      rp,
    output logic            branchTaken,
    output z8Pkg::byteT     branchTarget,
    output z8Pkg::byteT     readAddrA,
    output z8Pkg::byteT     readAddrB,
    output z8Pkg::regWriteT regWrite,
    output logic            flagsWrite,
    output z8Pkg::flagsT    flagsNext
);
    import z8Pkg::*;

    logic [3:0] opHi;
    logic [3:0] opLo;
    logic       isAluRr, isAluIm, isAlu;
    logic       isLdRegIm, isLdWorkIm, isLdWorkReg, isSrp, isLoad;
    logic       isCarryOp, isJr, isJp;
    logic       dstMapped, condMet, aluWrites;
    byteT       dstAddr, operandB, aluResult;
    aluOpT      aluOp;
    flagsT      aluFlags, carryFlags;
    logic       wrValid;
    byteT       wrAddr, wrData;

    function automatic byteT regAddr(input byteT r, input logic [3:0] ptr);
        // E page selects a working register
        return (r[7:4] == WorkingPage) ? {ptr, r[3:0]} : r;
    endfunction

    assign opHi = instr.opcode[7:4];
    assign opLo = instr.opcode[3:0];

    assign isAluRr     = (!opHi[3] || opHi[3:1] == 3'b101) && opLo == NibAluRr;
    assign isAluIm     = (!opHi[3] || opHi[3:1] == 3'b101) && opLo == NibAluIm;
    assign isAlu       = isAluRr || isAluIm;
    assign isLdRegIm   = instr.opcode == OpLdRegIm;
    assign isLdWorkIm  = opLo == NibLdWorkIm;
    assign isLdWorkReg = opLo == NibLdWorkReg;
    assign isSrp       = instr.opcode == OpSrp;
    assign isLoad      = isLdRegIm || isLdWorkIm || isLdWorkReg || isSrp;
    assign isCarryOp   = instr.opcode == OpRcf || instr.opcode == OpScf
                      || instr.opcode == OpCcf;
    assign isJr        = opLo == NibJr;
    assign isJp        = opLo == NibJp;

    assign readAddrA = isAluRr ? {rp, instr.second[7:4]} : regAddr(instr.second, rp);
    assign readAddrB = isAluRr ? {rp, instr.second[3:0]} : regAddr(instr.second, rp);

    always_comb begin
        if (isAlu) begin
            dstAddr = readAddrA;
        end else if (isLdRegIm) begin
            dstAddr = regAddr(instr.second, rp);
        end else if (isSrp) begin
            dstAddr = RpAddr;
        end else begin
            dstAddr = {rp, opHi};
        end
        if (isAluRr || isLdWorkReg) begin
            operandB = readDataB;
        end else if (isAluIm || isLdRegIm) begin
            operandB = instr.third;
        end else begin
            operandB = instr.second;
        end
    end

    assign aluOp     = isAlu ? aluOpT'(opHi) : AluLd;
    assign dstMapped = int'(dstAddr) < numRegs || dstAddr == FlagsAddr || dstAddr == RpAddr;

    aluUnit i_aluUnit (
        .op          (aluOp),
        .a           (readDataA),
        .b           (operandB),
        .flagsIn     (flags),
        .result      (aluResult),
        .flagsOut    (aluFlags),
        .writesResult(aluWrites)
    );

    // rcf, scf set C from bit 4 of the opcode, ccf flips it
    always_comb begin
        carryFlags   = flags;
        carryFlags.c = (opHi == 4'hE) ? ~flags.c : opHi[0];
    end

    always_comb begin
        case (opHi[2:0])
            3'd0: condMet = 1'b0;
            3'd1: condMet = flags.s ^ flags.v;
            3'd2: condMet = (flags.s ^ flags.v) | flags.z;
            3'd3: condMet = flags.c | flags.z;
            3'd4: condMet = flags.v;
            3'd5: condMet = flags.s;
            3'd6: condMet = flags.z;
            default: condMet = flags.c;
        endcase
    end

    assign branchTaken  = decode && (isJr || isJp) && (condMet ^ opHi[3]);
    assign branchTarget = isJp ? instr.third : nextPc + instr.second;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrValid    <= 1'b0;
            flagsWrite <= 1'b0;
        end else begin
            wrValid    <= decode && dstMapped && (isLoad || (isAlu && aluWrites));
            flagsWrite <= decode && (isAlu || isCarryOp);
        end
    end

    always_ff @(posedge clk) begin
        if (decode) begin
            wrAddr    <= dstAddr;
            wrData    <= aluResult;
            flagsNext <= isCarryOp ? carryFlags : aluFlags;
        end
    end

    assign regWrite = '{valid: wrValid, addr: wrAddr, data: wrData};

endmodule

/* logic/z8Core.sv */
`timescale 1ns/100ps

module z8Core #(
    parameter int          numRegs = 128,
    parameter z8Pkg::byteT resetPc = 8'h00,
    parameter logic [3:0]  resetRp = 4'h0
) (
    input  logic            clk,
    input  logic            rstN,
    input  z8Pkg::byteT     memData,
    output logic            memStrobe,
    output z8Pkg::byteT     memAddr,
    output z8Pkg::regWriteT regWrite
);
    import z8Pkg::*;

    instrT      instr;
    logic       decode, branchTaken, flagsWrite;
    byteT       nextPc, branchTarget;
    byteT       readAddrA, readAddrB, readDataA, readDataB;
    flagsT      flags, flagsNext;
    logic [3:0] rp;

    instrFetch #(.resetPc(resetPc)) i_instrFetch (
        .clk         (clk),
        .rstN        (rstN),
        .memData     (memData),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget),
        .memStrobe   (memStrobe),
        .memAddr     (memAddr),
        .instr       (instr),
        .decode      (decode),
        .nextPc      (nextPc)
    );

    regFile #(.numRegs(numRegs), .resetRp(resetRp)) i_regFile (
        .clk       (clk),
        .rstN      (rstN),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .regWrite  (regWrite),
        .flagsWrite(flagsWrite),
        .flagsNext (flagsNext),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .flags     (flags),
        .rp        (rp)
    );

    execUnit #(.numRegs(numRegs)) i_execUnit (
        .clk         (clk),
        .rstN        (rstN),
        .instr       (instr),
        .decode      (decode),
        .nextPc      (nextPc),
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .flags       (flags),
        .rp          (rp),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget),
        .readAddrA   (readAddrA),
        .readAddrB   (readAddrB),
        .regWrite    (regWrite),
        .flagsWrite  (flagsWrite),
        .flagsNext   (flagsNext)
    );

endmodule

/* test/z8CoreTb.sv */
`timescale 1ns/100ps

module z8CoreTb;
    import z8Pkg::*;

    // 20 ALU programs of about 660 cycles each dominate the run
    localparam int MaxCycles   = 20000;
    localparam int ResetCycles = 16;

    logic     clk = 1'b0;
    logic     rstN;
    byteT     memData;
    logic     memStrobe;
    byteT     memAddr;
    regWriteT regWrite;

    byteT        mem [256];
    byteT        rdAddr;
    int          progLen;
    byteT        loopAddr;
    logic        running;
    int          loopHits;
    int          cycleCount;
    logic [31:0] lfsrState;

    // Reference model state
    byteT       modelRegs [128];
    flagsT      modelFlags;
    logic [3:0] modelRp;
    byteT       expFetch [$];
    regWriteT   expWrite [$];

    z8Core i_z8Core (
        .clk      (clk),
        .rstN     (rstN),
        .memData  (memData),
        .memStrobe(memStrobe),
        .memAddr  (memAddr),
        .regWrite (regWrite)
    );

    always #4 clk = ~clk;

    task automatic stopRun();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkFetch(input byteT got, input byteT exp);
        if (got !== exp) begin
            $display("ERROR %0t: fetch address %02h, expected %02h", $time, got, exp);
            stopRun();
        end
    endtask

    task automatic checkWrite(input regWriteT got, input regWriteT exp);
        if (got !== exp) begin
            $display("ERROR %0t: write %02h <= %02h, expected %02h <= %02h",
                     $time, got.addr, got.data, exp.addr, exp.data);
            stopRun();
        end
    endtask

    function automatic byteT randBits(input int n);
        byteT val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[6:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h8020_0003 : lfsrState >> 1;
        end
        return val;
    endfunction

    function automatic int lengthOf(input byteT op);
        if (op[3:0] == 4'hE || op[3:0] == 4'hF) begin
            return 1;
        end else if ((op[3:0] >= 4'h4 && op[3:0] <= 4'h7) || op[3:0] == 4'hD) begin
            return 3;
        end
        return 2;
    endfunction

    function automatic byteT workingAddr(input byteT r);
        return (r[7:4] == 4'hE) ? {modelRp, r[3:0]} : r;
    endfunction

    function automatic logic isMapped(input byteT addr);
        return addr < 8'h80 || addr == 8'hFC || addr == 8'hFD;
    endfunction

    function automatic byteT readModel(input byteT addr);
        if (addr == 8'hFC) begin
            return byteT'(modelFlags);
        end else if (addr == 8'hFD) begin
            return {modelRp, 4'h0};
        end else if (addr < 8'h80) begin
            return modelRegs[addr[6:0]];
        end
        return 8'h00;
    endfunction

    function automatic void writeModel(input byteT addr, input byteT data);
        regWriteT rec;
        rec.valid = 1'b1;
        rec.addr  = addr;
        rec.data  = data;
        if (isMapped(addr)) begin
            expWrite.push_back(rec);
            if (addr == 8'hFC) begin
                modelFlags = flagsT'(data);
            end else if (addr == 8'hFD) begin
                modelRp = data[7:4];
            end else begin
                modelRegs[addr[6:0]] = data;
            end
        end
    endfunction

    function automatic void referenceAlu(input logic [3:0] code, input byteT a, input byteT b,
                                         inout flagsT f, output byteT res, output logic wr);
        int   sum;
        int   sgn;
        logic cin;
        cin = (code == 4'h1 || code == 4'h3) ? f.c : 1'b0;
        wr  = 1'b1;
        case (code)
            4'h0, 4'h1: begin
                sum = int'(a) + int'(b) + int'(cin);
                sgn = int'($signed(a)) + int'($signed(b)) + int'(cin);
                res = byteT'(sum);
                f.c = sum > 255;
                f.v = sgn > 127 || sgn < -128;
            end
            4'h2, 4'h3, 4'hA: begin
                sum = int'(a) - int'(b) - int'(cin);
                sgn = int'($signed(a)) - int'($signed(b)) - int'(cin);
                res = byteT'(sum);
                f.c = sum < 0;
                f.v = sgn > 127 || sgn < -128;
                wr  = code != 4'hA;
            end
            4'h4: begin
                res = a | b;
                f.v = 1'b0;
            end
            4'h5, 4'h7: begin
                res = a & b;
                f.v = 1'b0;
                wr  = code == 4'h5;
            end
            4'h6: begin
                res = ~a & b;
                f.v = 1'b0;
                wr  = 1'b0;
            end
            4'hB: begin
                res = a ^ b;
                f.v = 1'b0;
            end
            default: begin
                res = b;
                wr  = 1'b0;
            end
        endcase
        f.z = res == 8'h00;
        f.s = res[7];
    endfunction

    function automatic logic conditionHolds(input logic [3:0] cc);
        logic r;
        case (cc[2:0])
            3'd0: r = 1'b0;
            3'd1: r = modelFlags.s ^ modelFlags.v;
            3'd2: r = (modelFlags.s ^ modelFlags.v) | modelFlags.z;
            3'd3: r = modelFlags.c | modelFlags.z;
            3'd4: r = modelFlags.v;
            3'd5: r = modelFlags.s;
            3'd6: r = modelFlags.z;
            default: r = modelFlags.c;
        endcase
        return r ^ cc[3];
    endfunction

    function automatic void executeModel(input byteT op, input byteT b2, input byteT b3,
                                         input byteT after, inout byteT pc);
        logic [3:0] hi;
        logic [3:0] lo;
        byteT       dst;
        byteT       a;
        byteT       b;
        byteT       res;
        flagsT      f;
        logic       wr;
        hi = op[7:4];
        lo = op[3:0];
        if ((hi <= 4'h7 || hi == 4'hA || hi == 4'hB) && (lo == 4'h2 || lo == 4'h6)) begin
            if (lo == 4'h2) begin
                dst = {modelRp, b2[7:4]};
                b   = readModel({modelRp, b2[3:0]});
            end else begin
                dst = workingAddr(b2);
                b   = b3;
            end
            a = readModel(dst);
            f = modelFlags;
            referenceAlu(hi, a, b, f, res, wr);
            // A write to FC lands after the flag update
            modelFlags = f;
            if (wr) begin
                writeModel(dst, res);
            end
        end else if (op == 8'hE6) begin
            writeModel(workingAddr(b2), b3);
        end else if (lo == 4'hC) begin
            writeModel({modelRp, hi}, b2);
        end else if (lo == 4'h8) begin
            writeModel({modelRp, hi}, readModel(workingAddr(b2)));
        end else if (op == 8'h31) begin
            writeModel(8'hFD, b2);
        end else if (op == 8'hCF) begin
            modelFlags.c = 1'b0;
        end else if (op == 8'hDF) begin
            modelFlags.c = 1'b1;
        end else if (op == 8'hEF) begin
            modelFlags.c = ~modelFlags.c;
        end else if ((lo == 4'hB || lo == 4'hD) && conditionHolds(hi)) begin
            pc = (lo == 4'hB) ? byteT'(after + b2) : b3;
        end
    endfunction

    // Expected strobe addresses and writes up to the second loop fetch
    task automatic simulateProgram();
        byteT pc;
        byteT after;
        int   len;
        int   visits;
        pc         = 8'h00;
        visits     = 0;
        modelFlags = '0;
        modelRp    = 4'h0;
        expFetch.delete();
        expWrite.delete();
        while (visits < 2) begin
            expFetch.push_back(pc);
            if (pc == loopAddr) begin
                visits++;
            end
            if (visits < 2) begin
                len = lengthOf(mem[pc]);
                for (int i = 1; i < len; i++) begin
                    expFetch.push_back(byteT'(pc + byteT'(i)));
                end
                after = byteT'(pc + byteT'(len));
                executeModel(mem[pc], mem[byteT'(pc + 8'd1)], mem[byteT'(pc + 8'd2)],
                             after, after);
                pc = after;
            end
        end
    endtask

    task automatic startProgram();
        running = 1'b0;
        @(negedge clk);
        rstN = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = byteT'(i) ^ 8'h6B;
        end
        progLen = 0;
    endtask

    task automatic emitInstr(input int len, input byteT b1, input byteT b2 = 8'h00,
                             input byteT b3 = 8'h00);
        mem[progLen] = b1;
        if (len > 1) begin
            mem[progLen + 1] = b2;
        end
        if (len > 2) begin
            mem[progLen + 2] = b3;
        end
        progLen += len;
    endtask

    task automatic runProgram();
        loopAddr = byteT'(progLen);
        // jr always to itself
        emitInstr(2, 8'h8B, 8'hFE);
        simulateProgram();
        repeat (ResetCycles) @(negedge clk);
        loopHits = 0;
        running  = 1'b1;
        rstN     = 1'b1;
        wait (loopHits == 2);
        running = 1'b0;
        if (expFetch.size() != 0 || expWrite.size() != 0) begin
            $display("The core reached its final loop with fetches or writes still missing");
            stopRun();
        end
    endtask

    task automatic testFetchLength();
        byteT ops [12];
        ops = '{8'hFF, 8'h00, 8'h04, 8'h0E, 8'h8C, 8'h1F, 8'h09, 8'h47, 8'hE6, 8'h35,
                8'h1A, 8'h8E};
        startProgram();
        for (int rep = 0; rep < 3; rep++) begin
            for (int k = 0; k < 12; k++) begin
                emitInstr(lengthOf(ops[k]), ops[k], randBits(8), randBits(8));
            end
        end
        runProgram();
    endtask

    task automatic testLoadsAddressing();
        startProgram();
        emitInstr(2, 8'h31, 8'h20);
        emitInstr(2, 8'h5C, randBits(8));
        emitInstr(3, 8'hE6, 8'hE7, randBits(8));
        emitInstr(3, 8'hE6, 8'h10, randBits(8));
        emitInstr(2, 8'h18, 8'h25);
        emitInstr(2, 8'h38, 8'hE7);
        emitInstr(3, 8'hE6, 8'hFD, 8'h40);
        emitInstr(2, 8'h2C, randBits(8));
        emitInstr(2, 8'h48, 8'h21);
        emitInstr(2, 8'h68, 8'h10);
        runProgram();
    endtask

    task automatic testAluOps();
        logic [3:0] codes [10];
        byteT       a;
        byteT       b;
        codes = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'hA, 4'hB};
        for (int k = 0; k < 10; k++) begin
            // Two programs per operation, 20 pairs each
            for (int half = 0; half < 2; half++) begin
                startProgram();
                for (int p = 0; p < 20; p++) begin
                    a = randBits(8);
                    b = randBits(8);
                    emitInstr(2, 8'h0C, a);
                    emitInstr(2, 8'h1C, b);
                    emitInstr(2, {codes[k], 4'h2}, 8'h01);
                    emitInstr(2, 8'h2C, a);
                    emitInstr(3, {codes[k], 4'h6}, 8'hE2, b);
                end
                runProgram();
            end
        end
    endtask

    task automatic testBranches();
        byteT aluPick [4];
        byteT pick;
        aluPick = '{8'h02, 8'h22, 8'hA2, 8'h52};
        for (int form = 0; form < 2; form++) begin
            startProgram();
            for (int cc = 0; cc < 16; cc++) begin
                emitInstr(2, 8'h0C, randBits(8));
                emitInstr(2, 8'h1C, randBits(8));
                pick = randBits(2);
                emitInstr(2, aluPick[pick[1:0]], 8'h01);
                pick = randBits(2);
                case (pick[1:0])
                    2'd1: emitInstr(1, 8'hCF);
                    2'd2: emitInstr(1, 8'hDF);
                    2'd3: emitInstr(1, 8'hEF);
                    default: ;
                endcase
                // Taken jumps skip the marker load
                if (form == 0) begin
                    emitInstr(2, byteT'(cc * 16 + 11), 8'h02);
                end else begin
                    emitInstr(3, byteT'(cc * 16 + 13), 8'h00, byteT'(progLen + 5));
                end
                emitInstr(2, 8'h3C, byteT'(cc));
            end
            runProgram();
        end
    endtask

    task automatic testFlagRegister();
        startProgram();
        for (int i = 0; i < 8; i++) begin
            emitInstr(3, 8'hE6, 8'hFC, randBits(8));
            emitInstr(2, 8'h6B, 8'h02);
            emitInstr(2, 8'h3C, byteT'(i));
            emitInstr(2, 8'h7B, 8'h02);
            emitInstr(2, 8'h4C, byteT'(i));
            emitInstr(3, 8'h06, 8'hFC, randBits(8));
            emitInstr(2, 8'h7B, 8'h02);
            emitInstr(2, 8'h5C, byteT'(i));
        end
        runProgram();
    endtask

    // Synchronous one-cycle program memory
    always @(posedge clk) begin
        if (memStrobe) begin
            rdAddr = memAddr;
        end
    end

    always @(negedge clk) begin
        memData = mem[rdAddr];
    end

    always @(posedge clk) begin
        if (running && rstN) begin
            if (memStrobe) begin
                if (expFetch.size() == 0) begin
                    $display("The core fetched beyond the end of the expected sequence");
                    stopRun();
                end else begin
                    checkFetch(memAddr, expFetch.pop_front());
                    if (memAddr == loopAddr) begin
                        loopHits++;
                    end
                end
            end
            if (regWrite.valid) begin
                if (expWrite.size() == 0) begin
                    $display("The core wrote register %02h when no write was due", regWrite.addr);
                    stopRun();
                end else begin
                    checkWrite(regWrite, expWrite.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            $display("Timeout after %0d cycles without finishing the tests", cycleCount);
            stopRun();
        end
    end

    initial begin
        rstN       = 1'b0;
        memData    = 8'h00;
        rdAddr     = 8'h00;
        running    = 1'b0;
        loopHits   = 0;
        loopAddr   = 8'h00;
        progLen    = 0;
        cycleCount = 0;
        lfsrState  = 32'hd4f4_6c73;
        for (int i = 0; i < 128; i++) begin
            modelRegs[i] = 8'h00;
        end
        testFetchLength();
        testLoadsAddressing();
        testAluOps();
        testBranches();
        testFlagRegister();
        $display("Test passed");
        $finish;
    end

endmodule

/* z8Core.f */
logic/z8Pkg.sv
logic/aluUnit.sv
logic/regFile.sv
logic/instrFetch.sv
logic/execUnit.sv
logic/z8Core.sv
test/z8CoreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= z8CoreTb
FILELIST  ?= z8Core.f
BUILDDIR  ?= obj_dir
LOG       ?= sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) --binary --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILDDIR) -o $(TOP)
	./$(BUILDDIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
